// ==== rtl/cmd_queue_bank.sv ====
// Per-accelerator circular command FIFOs, written by the host stream and popped by the dispatcher
`timescale 1ns/1ps

module cmd_queue_bank import manager_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      in_valid,
    input  acc_id_t   in_acc,
    input  cmd_word_t in_data,
    output logic      in_ready,
    cmd_queue_if.bank q
);

    cmd_word_t         mem [NUM_ACCS][QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr [NUM_ACCS];
    logic [QPTR_W-1:0] rd_ptr [NUM_ACCS];
    logic [QPTR_W:0]   fill [NUM_ACCS];
    acc_mask_t         full;
    acc_mask_t         push_sel;
    acc_mask_t         pop_sel;
    logic              push;

    always_comb begin
        for (int i = 0; i < NUM_ACCS; i++) begin
            full[i]     = (fill[i] == (QPTR_W + 1)'(QUEUE_DEPTH));
            q.nempty[i] = (fill[i] != '0);
        end
    end

    // Host is stalled only by the queue it addresses
    assign in_ready = ~full[in_acc];
    assign push     = in_valid & in_ready;

    always_comb begin
        for (int i = 0; i < NUM_ACCS; i++) begin
            push_sel[i] = push && (in_acc == acc_id_t'(i));
            pop_sel[i]  = q.pop && (q.pop_acc == acc_id_t'(i));
        end
    end

    assign q.head = mem[q.pop_acc][rd_ptr[q.pop_acc]];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[in_acc][wr_ptr[in_acc]] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_ACCS; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                fill[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ACCS; i++) begin
                if (push_sel[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;
                end
                if (pop_sel[i]) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end
                // Simultaneous push and pop leaves the fill level alone
                if (push_sel[i] && !pop_sel[i]) begin
                    fill[i] <= fill[i] + 1'b1;
                end else if (!push_sel[i] && pop_sel[i]) begin
                    fill[i] <= fill[i] - 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/cmd_queue_if.sv ====
// Link between the command queue bank and the dispatcher: occupancy, pop request and head word
`timescale 1ns/1ps

interface cmd_queue_if import manager_pkg::*; ();

    acc_mask_t nempty;
    logic      pop;
    acc_id_t   pop_acc;
    // Oldest word of queue pop_acc
    cmd_word_t head;

    modport bank (
        output nempty,
        output head,
        input  pop,
        input  pop_acc
    );

    modport ctrl (
        input  nempty,
        input  head,
        output pop,
        output pop_acc
    );

endinterface

// ==== rtl/dispatch_ctrl.sv ====
// Tracks accelerator availability and hands queued commands out in round-robin order
`timescale 1ns/1ps

module dispatch_ctrl import manager_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    cmd_queue_if.ctrl q,
    input  logic      done_valid,
    input  acc_id_t   done_acc,
    output logic      out_valid,
    input  logic      out_ready,
    output cmd_msg_t  out_msg
);

    acc_mask_t avail;
    acc_mask_t avail_next;
    acc_mask_t cand;
    acc_id_t   rr_ptr;
    acc_id_t   pick_acc;
    logic      pick_found;
    logic      grant;

    // Only idle accelerators with work waiting compete
    assign cand = avail & q.nempty;

    // Search starts just after the last granted accelerator
    always_comb begin
        acc_id_t idx;
        pick_found = 1'b0;
        pick_acc   = rr_ptr;
        for (int i = 1; i <= NUM_ACCS; i++) begin
            idx = rr_ptr + acc_id_t'(i);
            if (!pick_found && cand[idx]) begin
                pick_found = 1'b1;
                pick_acc   = idx;
            end
        end
    end

    assign grant     = pick_found & out_ready;
    assign q.pop     = grant;
    assign q.pop_acc = pick_acc;

    assign out_valid    = grant;
    assign out_msg.dest = pick_acc;
    assign out_msg.data = q.head;

    always_comb begin
        avail_next = avail;
        if (done_valid) begin
            avail_next[done_acc] = 1'b1;
        end
        // A dispatched accelerator is busy until its completion comes back
        if (grant) begin
            avail_next[pick_acc] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            avail  <= '1;
            rr_ptr <= acc_id_t'(NUM_ACCS - 1);
        end else begin
            avail <= avail_next;
            if (grant) begin
                rr_ptr <= pick_acc;
            end
        end
    end

endmodule

// ==== rtl/lock_unit.sv ====
// Single global lock, granting ownership to one accelerator and answering every acquire
`timescale 1ns/1ps

module lock_unit import manager_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      req_valid,
    output logic      req_ready,
    input  acc_id_t   req_acc,
    input  logic      req_acquire,
    output logic      ack_valid,
    input  logic      ack_ready,
    output lock_ack_t ack_msg
);

    logic    locked;
    acc_id_t owner;
    logic    accept;

    // Requests wait whenever the ack path is blocked
    assign req_ready = ack_ready;
    assign accept    = req_valid & req_ready;

    // Releases are silent
    assign ack_valid       = accept & req_acquire;
    assign ack_msg.dest    = req_acc;
    assign ack_msg.granted = ~locked;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            locked <= 1'b0;
            owner  <= '0;
        end else if (accept) begin
            if (req_acquire) begin
                if (!locked) begin
                    locked <= 1'b1;
                    owner  <= req_acc;
                end
            end else if (locked && owner == req_acc) begin
                // Release from a non-owner is dropped
                locked <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/manager_pkg.sv ====
// Shared sizes, id and word types and output payload structs, imported by every design module
package manager_pkg;

    // Accelerator set
    localparam int NUM_ACCS = 8;
    localparam int ACC_W    = 3;

    // Per-accelerator command queues
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W      = 3;

    // Host command word
    localparam int DATA_W = 64;

    typedef logic [ACC_W-1:0]    acc_id_t;
    typedef logic [DATA_W-1:0]   cmd_word_t;
    typedef logic [NUM_ACCS-1:0] acc_mask_t;

    // Command handed to an accelerator on cmdin_out
    typedef struct packed {
        acc_id_t   dest;
        cmd_word_t data;
    } cmd_msg_t;

    // Answer to a lock acquire on lock_out
    typedef struct packed {
        acc_id_t dest;
        logic    granted;
    } lock_ack_t;

endpackage

// ==== rtl/stream_out_stage.sv ====
// One-entry registered valid/ready output stage, instantiated per outgoing stream payload type
`timescale 1ns/1ps

module stream_out_stage import manager_pkg::*; #(
    parameter type payload_t = cmd_msg_t
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full_q;
    payload_t data_q;

    // Refill allowed in the cycle the held item leaves
    assign in_ready = ~full_q | out_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            full_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            full_q <= 1'b1;
        end else if (out_ready) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full_q;
    assign out_data  = data_q;

endmodule

// ==== rtl/task_manager_top.sv ====
// Accelerator task manager top level, exposing the host command, completion and lock streams
`timescale 1ns/1ps

module task_manager_top import manager_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    // Host commands
    input  logic      cmd_in_tvalid,
    output logic      cmd_in_tready,
    input  acc_id_t   cmd_in_tid,
    input  cmd_word_t cmd_in_tdata,
    // Commands to accelerators
    output logic      cmdin_out_tvalid,
    input  logic      cmdin_out_tready,
    output acc_id_t   cmdin_out_tdest,
    output cmd_word_t cmdin_out_tdata,
    output logic      cmdin_out_tlast,
    // Completions
    input  logic      cmdout_in_tvalid,
    output logic      cmdout_in_tready,
    input  acc_id_t   cmdout_in_tid,
    // Lock requests
    input  logic      lock_in_tvalid,
    output logic      lock_in_tready,
    input  acc_id_t   lock_in_tid,
    input  cmd_word_t lock_in_tdata,
    // Lock acks
    output logic      lock_out_tvalid,
    input  logic      lock_out_tready,
    output acc_id_t   lock_out_tdest,
    output cmd_word_t lock_out_tdata,
    output logic      lock_out_tlast
);

    cmd_queue_if cq_if ();

    logic      disp_valid;
    logic      disp_ready;
    cmd_msg_t  disp_msg;
    cmd_msg_t  cmd_out_msg;
    logic      ack_valid;
    logic      ack_ready;
    lock_ack_t ack_msg;
    lock_ack_t lock_out_msg;

    cmd_queue_bank bank_i (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (cmd_in_tvalid),
        .in_acc   (cmd_in_tid),
        .in_data  (cmd_in_tdata),
        .in_ready (cmd_in_tready),
        .q        (cq_if.bank)
    );

    dispatch_ctrl ctrl_i (
        .clk        (clk),
        .rstn       (rstn),
        .q          (cq_if.ctrl),
        .done_valid (cmdout_in_tvalid),
        .done_acc   (cmdout_in_tid),
        .out_valid  (disp_valid),
        .out_ready  (disp_ready),
        .out_msg    (disp_msg)
    );

    stream_out_stage #(.payload_t(cmd_msg_t)) cmd_stage_i (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (disp_valid),
        .in_ready  (disp_ready),
        .in_data   (disp_msg),
        .out_valid (cmdin_out_tvalid),
        .out_ready (cmdin_out_tready),
        .out_data  (cmd_out_msg)
    );

    lock_unit lock_i (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (lock_in_tvalid),
        .req_ready   (lock_in_tready),
        .req_acc     (lock_in_tid),
        .req_acquire (lock_in_tdata[0]),
        .ack_valid   (ack_valid),
        .ack_ready   (ack_ready),
        .ack_msg     (ack_msg)
    );

    stream_out_stage #(.payload_t(lock_ack_t)) lock_stage_i (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (ack_valid),
        .in_ready  (ack_ready),
        .in_data   (ack_msg),
        .out_valid (lock_out_tvalid),
        .out_ready (lock_out_tready),
        .out_data  (lock_out_msg)
    );

    // Completions are always taken
    assign cmdout_in_tready = 1'b1;

    assign cmdin_out_tdest = cmd_out_msg.dest;
    assign cmdin_out_tdata = cmd_out_msg.data;
    assign cmdin_out_tlast = 1'b1;

    assign lock_out_tdest = lock_out_msg.dest;
    assign lock_out_tdata = {{(DATA_W - 1){1'b0}}, lock_out_msg.granted};
    assign lock_out_tlast = 1'b1;

endmodule

// ==== sources.f ====
rtl/manager_pkg.sv
rtl/cmd_queue_if.sv
rtl/cmd_queue_bank.sv
rtl/dispatch_ctrl.sv
rtl/stream_out_stage.sv
rtl/lock_unit.sv
rtl/task_manager_top.sv
tb/task_manager_chk.sv
tb/tb_task_manager.sv

// ==== tb/task_manager_chk.sv ====
// Stream protocol assertions bound into the task manager top level during simulation
`timescale 1ns/1ps

module task_manager_chk import manager_pkg::*; (
    input logic      clk,
    input logic      rstn,
    input logic      cmdin_out_tvalid,
    input logic      cmdin_out_tready,
    input acc_id_t   cmdin_out_tdest,
    input cmd_word_t cmdin_out_tdata,
    input logic      lock_out_tvalid,
    input logic      lock_out_tready,
    input acc_id_t   lock_out_tdest,
    input cmd_word_t lock_out_tdata,
    input logic      cmdout_in_tready
);

    // Read by the testbench when it decides the result
    int assert_errors = 0;

    cmd_hold_a: assert property (@(posedge clk) disable iff (!rstn)
        cmdin_out_tvalid && !cmdin_out_tready |=> cmdin_out_tvalid
            && $stable(cmdin_out_tdest) && $stable(cmdin_out_tdata))
        else begin
            assert_errors++;
            $error("cmdin_out valid or payload changed while stalled");
        end

    lock_hold_a: assert property (@(posedge clk) disable iff (!rstn)
        lock_out_tvalid && !lock_out_tready |=> lock_out_tvalid
            && $stable(lock_out_tdest) && $stable(lock_out_tdata))
        else begin
            assert_errors++;
            $error("lock_out valid or payload changed while stalled");
        end

    // Completions can never be refused
    done_ready_a: assert property (@(posedge clk) disable iff (!rstn) cmdout_in_tready)
        else begin
            assert_errors++;
            $error("cmdout_in_tready went low");
        end

endmodule

bind task_manager_top task_manager_chk chk_i (
    .clk              (clk),
    .rstn             (rstn),
    .cmdin_out_tvalid (cmdin_out_tvalid),
    .cmdin_out_tready (cmdin_out_tready),
    .cmdin_out_tdest  (cmdin_out_tdest),
    .cmdin_out_tdata  (cmdin_out_tdata),
    .lock_out_tvalid  (lock_out_tvalid),
    .lock_out_tready  (lock_out_tready),
    .lock_out_tdest   (lock_out_tdest),
    .lock_out_tdata   (lock_out_tdata),
    .cmdout_in_tready (cmdout_in_tready)
);

// ==== tb/tb_task_manager.sv ====
// Directed testbench for the accelerator task manager, compiled from sources.f as simulation top
`timescale 1ns/1ps

module tb_task_manager import manager_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = 200;
    localparam int NUM_RANDOM   = 24;
    // Six tests, each well inside this many cycles
    localparam int TEST_CYCLES  = 600;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 6 * TEST_CYCLES) * CLK_PERIOD;

    logic      clk = 1'b0;
    logic      rstn;
    logic      cmd_in_tvalid;
    logic      cmd_in_tready;
    acc_id_t   cmd_in_tid;
    cmd_word_t cmd_in_tdata;
    logic      cmdin_out_tvalid;
    logic      cmdin_out_tready;
    acc_id_t   cmdin_out_tdest;
    cmd_word_t cmdin_out_tdata;
    logic      cmdin_out_tlast;
    logic      cmdout_in_tvalid;
    logic      cmdout_in_tready;
    acc_id_t   cmdout_in_tid;
    logic      lock_in_tvalid;
    logic      lock_in_tready;
    acc_id_t   lock_in_tid;
    cmd_word_t lock_in_tdata;
    logic      lock_out_tvalid;
    logic      lock_out_tready;
    acc_id_t   lock_out_tdest;
    cmd_word_t lock_out_tdata;
    logic      lock_out_tlast;

    logic [31:0] lfsr = 32'h344bb5f8;
    // Expected words per accelerator, oldest first
    cmd_word_t   exp_q [NUM_ACCS][$];
    acc_mask_t   busy = '0;
    int          delivered = 0;
    int          mismatch_count = 0;
    int          fail_count = 0;

    task_manager_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic note_mismatch(input string name, input logic [63:0] want,
                                 input logic [63:0] got);
        mismatch_count++;
        $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h", $time, name, want, got);
    endtask

    task automatic note_failure(input string what);
        fail_count++;
        $display("ERROR time=%0t %s", $time, what);
    endtask

    // Every beat on cmdin_out is checked against the queue model
    always @(posedge clk) begin
        cmd_word_t want;
        if (rstn && cmdin_out_tvalid && cmdin_out_tready) begin
            if (busy[cmdin_out_tdest])
                note_failure($sformatf("accelerator %0d got a command before its completion",
                                       cmdin_out_tdest));
            if (exp_q[cmdin_out_tdest].size() == 0) begin
                note_failure($sformatf("unexpected command for accelerator %0d",
                                       cmdin_out_tdest));
            end else begin
                want = exp_q[cmdin_out_tdest].pop_front();
                if (cmdin_out_tdata !== want)
                    note_mismatch("cmdin_out_tdata", want, cmdin_out_tdata);
            end
            if (cmdin_out_tlast !== 1'b1)
                note_mismatch("cmdin_out_tlast", 1, cmdin_out_tlast);
            busy[cmdin_out_tdest] = 1'b1;
            delivered++;
        end
    end

    task automatic push_cmd(input acc_id_t id, input cmd_word_t data);
        int waited = 0;
        @(negedge clk);
        cmd_in_tvalid = 1'b1;
        cmd_in_tid    = id;
        cmd_in_tdata  = data;
        @(posedge clk);
        while (!cmd_in_tready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (cmd_in_tready)
            exp_q[id].push_back(data);
        else
            note_failure($sformatf("command for accelerator %0d never accepted", id));
        @(negedge clk);
        cmd_in_tvalid = 1'b0;
    endtask

    task automatic send_done(input acc_id_t id);
        @(negedge clk);
        cmdout_in_tvalid = 1'b1;
        cmdout_in_tid    = id;
        @(negedge clk);
        cmdout_in_tvalid = 1'b0;
        busy[id] = 1'b0;
    endtask

    task automatic wait_delivered(input int target);
        int waited = 0;
        while (delivered < target && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (delivered < target)
            note_failure($sformatf("only %0d of %0d commands delivered", delivered, target));
        @(negedge clk);
    endtask

    // Completes busy accelerators until the target count has been delivered
    task automatic serve_done(input int target);
        int idle = 0;
        int pick;
        while ((delivered < target || busy != '0) && idle < WAIT_LIMIT) begin
            if (busy != '0) begin
                pick = 0;
                for (int i = NUM_ACCS - 1; i >= 0; i--) begin
                    if (busy[i]) pick = i;
                end
                send_done(acc_id_t'(pick));
                idle = 0;
            end else begin
                @(negedge clk);
                idle++;
            end
        end
        if (delivered < target || busy != '0)
            note_failure($sformatf("traffic stuck at %0d of %0d commands", delivered, target));
    endtask

    task automatic lock_request(input acc_id_t id, input logic acquire, input logic granted);
        int waited = 0;
        cmd_word_t req;
        req = rand_bits(DATA_W);
        req[0] = acquire;
        @(negedge clk);
        lock_in_tvalid = 1'b1;
        lock_in_tid    = id;
        lock_in_tdata  = req;
        @(posedge clk);
        while (!lock_in_tready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!lock_in_tready) note_failure("lock request never accepted");
        @(negedge clk);
        lock_in_tvalid = 1'b0;
        // Ack is due exactly one cycle after acceptance
        @(posedge clk);
        if (lock_out_tvalid !== acquire) note_mismatch("lock_out_tvalid", acquire, lock_out_tvalid);
        if (acquire && lock_out_tdest !== id) note_mismatch("lock_out_tdest", id, lock_out_tdest);
        if (acquire && lock_out_tdata !== 64'(granted))
            note_mismatch("lock_out_tdata", 64'(granted), lock_out_tdata);
        if (acquire && lock_out_tlast !== 1'b1) note_mismatch("lock_out_tlast", 1, lock_out_tlast);
    endtask

    task automatic check_after_reset;
        @(negedge clk);
        if (cmdin_out_tvalid !== 1'b0) note_mismatch("cmdin_out_tvalid", 0, cmdin_out_tvalid);
        if (lock_out_tvalid !== 1'b0) note_mismatch("lock_out_tvalid", 0, lock_out_tvalid);
        for (int i = 0; i < NUM_ACCS; i++) push_cmd(acc_id_t'(i), rand_bits(DATA_W));
        wait_delivered(NUM_ACCS);
        if (busy !== '1) note_mismatch("busy accelerators", acc_mask_t'('1), busy);
        serve_done(delivered);
    endtask

    task automatic check_push_order;
        int start;
        start = delivered;
        for (int i = 0; i < 4; i++) push_cmd(3'd5, rand_bits(DATA_W));
        wait_delivered(start + 1);
        repeat (10) @(posedge clk);
        if (delivered != start + 1) note_failure("second command sent without a completion");
        for (int i = 2; i <= 4; i++) begin
            send_done(3'd5);
            wait_delivered(start + i);
        end
        send_done(3'd5);
    endtask

    task automatic random_traffic;
        int start;
        start = delivered;
        fork
            begin
                for (int i = 0; i < NUM_RANDOM; i++)
                    push_cmd(acc_id_t'(rand_bits(ACC_W)), rand_bits(DATA_W));
            end
            serve_done(start + NUM_RANDOM);
        join
        for (int i = 0; i < NUM_ACCS; i++) begin
            if (exp_q[i].size() != 0)
                note_failure($sformatf("accelerator %0d still owed %0d commands", i,
                                       exp_q[i].size()));
        end
    endtask

    task automatic fill_one_queue;
        int start;
        cmd_word_t data;
        start = delivered;
        push_cmd(3'd2, rand_bits(DATA_W));
        wait_delivered(start + 1);
        for (int i = 0; i < QUEUE_DEPTH; i++) push_cmd(3'd2, rand_bits(DATA_W));
        data = rand_bits(DATA_W);
        @(negedge clk);
        cmd_in_tvalid = 1'b1;
        cmd_in_tid    = 3'd2;
        cmd_in_tdata  = data;
        @(posedge clk);
        if (cmd_in_tready !== 1'b0) note_mismatch("cmd_in_tready", 0, cmd_in_tready);
        // Another accelerator must still get through
        @(negedge clk);
        cmd_in_tid = 3'd6;
        @(posedge clk);
        if (cmd_in_tready === 1'b1) exp_q[6].push_back(data);
        else note_mismatch("cmd_in_tready", 1, cmd_in_tready);
        @(negedge clk);
        cmd_in_tvalid = 1'b0;
        serve_done(start + QUEUE_DEPTH + 2);
    endtask

    task automatic stall_output;
        int start;
        int waited = 0;
        acc_id_t held_dest;
        cmd_word_t held_data;
        start = delivered;
        @(negedge clk);
        cmdin_out_tready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            push_cmd(3'd1, rand_bits(DATA_W));
            push_cmd(3'd3, rand_bits(DATA_W));
        end
        while (!cmdin_out_tvalid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cmdin_out_tvalid) note_failure("no command offered while stalled");
        held_dest = cmdin_out_tdest;
        held_data = cmdin_out_tdata;
        repeat (8) begin
            @(posedge clk);
            if (cmdin_out_tvalid !== 1'b1) note_mismatch("cmdin_out_tvalid", 1, cmdin_out_tvalid);
            if (cmdin_out_tdest !== held_dest)
                note_mismatch("cmdin_out_tdest", held_dest, cmdin_out_tdest);
            if (cmdin_out_tdata !== held_data)
                note_mismatch("cmdin_out_tdata", held_data, cmdin_out_tdata);
        end
        if (delivered != start) note_failure("command taken while cmdin_out_tready was low");
        @(negedge clk);
        cmdin_out_tready = 1'b1;
        serve_done(start + 6);
    endtask

    // A held ack blocks further requests until lock_out_tready returns
    task automatic stall_lock_ack;
        cmd_word_t req;
        req = rand_bits(DATA_W);
        req[0] = 1'b1;
        @(negedge clk);
        lock_out_tready = 1'b0;
        lock_request(3'd2, 1'b1, 1'b1);
        @(negedge clk);
        lock_in_tvalid = 1'b1;
        lock_in_tid    = 3'd6;
        lock_in_tdata  = req;
        repeat (4) begin
            @(posedge clk);
            if (lock_in_tready !== 1'b0) note_mismatch("lock_in_tready", 0, lock_in_tready);
            if (lock_out_tvalid !== 1'b1) note_mismatch("lock_out_tvalid", 1, lock_out_tvalid);
            if (lock_out_tdest !== 3'd2) note_mismatch("lock_out_tdest", 2, lock_out_tdest);
            if (lock_out_tdata !== 64'd1) note_mismatch("lock_out_tdata", 1, lock_out_tdata);
        end
        @(negedge clk);
        lock_out_tready = 1'b1;
        @(posedge clk);
        if (lock_in_tready !== 1'b1) note_mismatch("lock_in_tready", 1, lock_in_tready);
        @(negedge clk);
        lock_in_tvalid = 1'b0;
        // Accelerator 2 still owns the lock
        @(posedge clk);
        if (lock_out_tvalid !== 1'b1) note_mismatch("lock_out_tvalid", 1, lock_out_tvalid);
        if (lock_out_tdest !== 3'd6) note_mismatch("lock_out_tdest", 6, lock_out_tdest);
        if (lock_out_tdata !== 64'd0) note_mismatch("lock_out_tdata", 0, lock_out_tdata);
        lock_request(3'd2, 1'b0, 1'b0);
    endtask

    task automatic lock_sequence;
        lock_request(3'd4, 1'b1, 1'b1);
        lock_request(3'd7, 1'b1, 1'b0);
        lock_request(3'd7, 1'b0, 1'b0);
        lock_request(3'd7, 1'b1, 1'b0);
        lock_request(3'd4, 1'b0, 1'b0);
        lock_request(3'd7, 1'b1, 1'b1);
        lock_request(3'd7, 1'b0, 1'b0);
        stall_lock_ack();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR watchdog expired after %0d ns with tests unfinished", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rstn             = 1'b0;
        cmd_in_tvalid    = 1'b0;
        cmd_in_tid       = '0;
        cmd_in_tdata     = '0;
        cmdin_out_tready = 1'b1;
        cmdout_in_tvalid = 1'b0;
        cmdout_in_tid    = '0;
        lock_in_tvalid   = 1'b0;
        lock_in_tid      = '0;
        lock_in_tdata    = '0;
        lock_out_tready  = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_after_reset();
        check_push_order();
        random_traffic();
        fill_one_queue();
        stall_output();
        lock_sequence();
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, fail_count, dut_i.chk_i.assert_errors);
        if (mismatch_count + fail_count + dut_i.chk_i.assert_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
